//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int ILEN = 32;

	// ####################
	// Major opcodes
	// ####################

	localparam logic [6:0] OPC_LUI       = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
	localparam logic [6:0] OPC_JAL       = 7'b1101111;
	localparam logic [6:0] OPC_JALR      = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
	localparam logic [6:0] OPC_LOAD      = 7'b0000011;
	localparam logic [6:0] OPC_STORE     = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
	localparam logic [6:0] OPC_OP_32     = 7'b0111011;
	localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;
	localparam logic [6:0] OPC_FENCE     = 7'b0001111;

	// ####################
	// Operand selects
	// ####################

	typedef enum logic [1:0] {
		V1_RS1  = 2'd0, // First operand from rs1.
		V1_PC   = 2'd1,
		V1_ZIMM = 2'd2  // Zero-extended rs1 field of CSR immediate forms.
	} v1_sel_e;

	typedef enum logic {
		V2_RS2 = 1'b0,
		V2_IMM = 1'b1
	} v2_sel_e;

endpackage

//--- rtl/rv_exec_pkg.sv
package rv_exec_pkg;

	// ####################
	// Datapath geometry
	// ####################

	localparam int XLEN     = 64; // Integer register width.
	localparam int REG_AW   = 5;  // Register index width.
	localparam int NUM_REGS = 32;

endpackage

//--- rtl/rv_dec_if.sv
interface rv_dec_if;
	import rv_isa_pkg::*;
	import rv_exec_pkg::*;

	logic [6:0]        opcode;
	logic [2:0]        func3;
	logic              func7;   // Instruction bit 30 only.
	logic [REG_AW-1:0] rs1;
	logic [REG_AW-1:0] rs2;
	logic [REG_AW-1:0] rd;
	logic [XLEN-1:0]   imme;    // Sign-extended per format.
	v1_sel_e           v1_type;
	v2_sel_e           v2_type;
	logic              mul_en;

	modport dec (
		output opcode, func3, func7, rs1, rs2, rd, imme, v1_type, v2_type, mul_en
	);

	modport consumer (
		input opcode, func3, func7, rs1, rs2, rd, imme, v1_type, v2_type, mul_en
	);

endinterface

//--- rtl/rv_decode.sv
module rv_decode (
	input logic [rv_isa_pkg::ILEN-1:0] instr,
	rv_dec_if.dec                      dec
);
	import rv_isa_pkg::*;
	import rv_exec_pkg::*;

	logic [6:0] opc;
	logic       i_type;
	logic       u_type;
	logic       j_type;
	logic       b_type;
	logic       s_type;
	logic       r_type;

	assign opc = instr[6:0];

	// ####################
	// Format classes
	// ####################

	assign i_type = opc inside {OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32, OPC_SYSTEM};
	assign u_type = opc inside {OPC_LUI, OPC_AUIPC};
	assign j_type = opc == OPC_JAL;
	assign b_type = opc == OPC_BRANCH;
	assign s_type = opc == OPC_STORE;
	assign r_type = opc inside {OPC_OP, OPC_OP_32};

	// ####################
	// Fields
	// ####################

	assign dec.opcode = opc;
	assign dec.func3  = instr[14:12];
	assign dec.func7  = instr[30];

	assign dec.rs1 = u_type ? '0 : instr[19:15]; // LUI then adds the immediate to x0.
	assign dec.rs2 = (i_type || u_type) ? '0 : instr[24:20];
	assign dec.rd  = (s_type || b_type) ? '0 : instr[11:7];

	assign dec.v1_type = (j_type || opc == OPC_AUIPC) ? V1_PC :
		(opc == OPC_SYSTEM && instr[14]) ? V1_ZIMM : V1_RS1;

	assign dec.v2_type = (r_type || b_type) ? V2_RS2 : V2_IMM;

	assign dec.mul_en = r_type && instr[25]; // M-extension sits in func7 bit 0.

	assign dec.imme =
		i_type ? {{(XLEN-12){instr[31]}}, instr[31:20]} :
		u_type ? {{(XLEN-32){instr[31]}}, instr[31:12], 12'b0} :
		j_type ? {{(XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0} :
		b_type ? {{(XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0} :
		s_type ? {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]} :
		'0;

endmodule

//--- rtl/rv_regfile.sv
module rv_regfile (
	input  logic                              clk,
	input  logic                              reset,
	rv_dec_if.consumer                        dec,
	output logic [rv_exec_pkg::XLEN-1:0]      rs1_data,
	output logic [rv_exec_pkg::XLEN-1:0]      rs2_data,
	input  logic                              wr_en,
	input  logic [rv_exec_pkg::REG_AW-1:0]    wr_addr,
	input  logic [rv_exec_pkg::XLEN-1:0]      wr_data
);
	import rv_exec_pkg::*;

	logic [XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data; // x0 stays zero.
		end
	end

	assign rs1_data = regs[dec.rs1];
	assign rs2_data = regs[dec.rs2];

	a_x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
		(dec.rs1 == '0) |-> (rs1_data == '0))
		else $error("x0 read back nonzero value %h", rs1_data);

endmodule

//--- rtl/rv_alu.sv
module rv_alu (
	rv_dec_if.consumer                    dec,
	input  logic [rv_exec_pkg::XLEN-1:0]  pc,
	input  logic [rv_exec_pkg::XLEN-1:0]  rs1_data,
	input  logic [rv_exec_pkg::XLEN-1:0]  rs2_data,
	output logic [rv_exec_pkg::XLEN-1:0]  result,
	output logic                          branch_taken,
	output logic [rv_exec_pkg::XLEN-1:0]  target
);
	import rv_isa_pkg::*;
	import rv_exec_pkg::*;

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] sra_res;
	logic [31:0]     sraw_res;
	logic [XLEN-1:0] arith;
	logic [31:0]     word_res;
	logic            is_sub;
	logic            signed_lt;
	logic            unsigned_lt;
	logic            cond;

	assign op_a = (dec.v1_type == V1_PC) ? pc : rs1_data;
	assign op_b = (dec.v2_type == V2_RS2) ? rs2_data : dec.imme;

	assign is_sub      = dec.func7 && (dec.opcode inside {OPC_OP, OPC_OP_32});
	assign sum         = op_a + op_b;
	assign signed_lt   = $signed(op_a) < $signed(op_b);
	assign unsigned_lt = op_a < op_b;
	assign sra_res     = $unsigned($signed(op_a) >>> op_b[5:0]);
	assign sraw_res    = $unsigned($signed(op_a[31:0]) >>> op_b[4:0]);

	// ####################
	// Integer operations
	// ####################

	always_comb begin
		case (dec.func3)
			3'd0: arith = is_sub ? op_a - op_b : sum;
			3'd1: arith = op_a << op_b[5:0];
			3'd2: arith = {{(XLEN-1){1'b0}}, signed_lt};
			3'd3: arith = {{(XLEN-1){1'b0}}, unsigned_lt};
			3'd4: arith = op_a ^ op_b;
			3'd5: arith = dec.func7 ? sra_res : op_a >> op_b[5:0];
			3'd6: arith = op_a | op_b;
			default: arith = op_a & op_b;
		endcase
	end

	always_comb begin
		case (dec.func3)
			3'd1: word_res = op_a[31:0] << op_b[4:0];
			3'd5: word_res = dec.func7 ? sraw_res : op_a[31:0] >> op_b[4:0];
			default: word_res = is_sub ? op_a[31:0] - op_b[31:0] : sum[31:0];
		endcase
	end

	always_comb begin
		case (dec.func3)
			3'b000: cond = op_a == op_b;
			3'b001: cond = op_a != op_b;
			3'b100: cond = signed_lt;
			3'b101: cond = !signed_lt;
			3'b110: cond = unsigned_lt;
			3'b111: cond = !unsigned_lt;
			default: cond = 1'b0;
		endcase
	end

	always_comb begin
		result       = arith;
		branch_taken = 1'b0;
		target       = pc + dec.imme;
		case (dec.opcode)
			OPC_LUI, OPC_AUIPC: result = sum;
			OPC_OP_32, OPC_OP_IMM_32: result = {{(XLEN-32){word_res[31]}}, word_res};
			OPC_JAL: begin
				result       = pc + XLEN'(4); // Link address.
				branch_taken = 1'b1;
			end
			OPC_JALR: begin
				result       = pc + XLEN'(4);
				branch_taken = 1'b1;
				target       = {sum[XLEN-1:1], 1'b0};
			end
			OPC_BRANCH: branch_taken = cond;
			default: ;
		endcase
	end

endmodule

//--- rtl/rv_muldiv.sv
module rv_muldiv #(
	parameter int MD_BITS_PER_CYCLE = 2
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          start,
	rv_dec_if.consumer                    dec,
	input  logic [rv_exec_pkg::XLEN-1:0]  rs1_data,
	input  logic [rv_exec_pkg::XLEN-1:0]  rs2_data,
	output logic                          done,
	output logic [rv_exec_pkg::XLEN-1:0]  result
);
	import rv_isa_pkg::*;
	import rv_exec_pkg::*;

	localparam int STEPS = XLEN / MD_BITS_PER_CYCLE;
	localparam int CW    = $clog2(STEPS + 1);

	logic              active;
	logic [CW-1:0]     cnt;
	logic              is_div;
	logic              is_word;
	logic              sel_hi;  // High product half, or remainder.
	logic              neg_res;
	logic              neg_rem;
	logic              word_in;
	logic              a_signed;
	logic              b_signed;
	logic [XLEN-1:0]   src_a;
	logic [XLEN-1:0]   src_b;
	logic              a_neg;
	logic              b_neg;
	logic [XLEN-1:0]   mag_a;
	logic [XLEN-1:0]   mag_b;
	logic [2*XLEN-1:0] prod;
	logic [2*XLEN-1:0] prod_nx;
	logic [2*XLEN-1:0] mcand;
	logic [XLEN-1:0]   mplier;
	logic [XLEN:0]     rem;
	logic [XLEN:0]     rem_nx;
	logic [XLEN-1:0]   quo;
	logic [XLEN-1:0]   quo_nx;
	logic [XLEN-1:0]   dsor;
	logic [2*XLEN-1:0] prod_fix;
	logic [XLEN-1:0]   quo_fix;
	logic [XLEN-1:0]   rem_fix;
	logic [XLEN-1:0]   raw;
	logic [XLEN-1:0]   final_res;

	// ####################
	// Operand setup
	// ####################

	assign word_in = dec.opcode == OPC_OP_32;

	always_comb begin
		if (dec.func3[2]) begin
			a_signed = !dec.func3[0]; // DIV and REM are signed.
			b_signed = !dec.func3[0];
		end else begin
			a_signed = dec.func3 == 3'd1 || dec.func3 == 3'd2;
			b_signed = dec.func3 == 3'd1;
		end
		if (word_in) begin
			src_a = {{(XLEN-32){a_signed & rs1_data[31]}}, rs1_data[31:0]};
			src_b = {{(XLEN-32){b_signed & rs2_data[31]}}, rs2_data[31:0]};
		end else begin
			src_a = rs1_data;
			src_b = rs2_data;
		end
	end

	assign a_neg = a_signed && src_a[XLEN-1];
	assign b_neg = b_signed && src_b[XLEN-1];
	assign mag_a = a_neg ? -src_a : src_a;
	assign mag_b = b_neg ? -src_b : src_b;

	// ####################
	// Iteration step
	// ####################

	always_comb begin
		prod_nx = prod;
		rem_nx  = rem;
		quo_nx  = quo;
		for (int i = 0; i < MD_BITS_PER_CYCLE; i++) begin
			if (mplier[i]) begin
				prod_nx = prod_nx + (mcand << i);
			end
			rem_nx = {rem_nx[XLEN-1:0], quo_nx[XLEN-1]};
			quo_nx = {quo_nx[XLEN-2:0], 1'b0};
			if (rem_nx >= {1'b0, dsor}) begin
				rem_nx    = rem_nx - {1'b0, dsor};
				quo_nx[0] = 1'b1;
			end
		end
	end

	assign prod_fix = neg_res ? -prod : prod;
	assign quo_fix  = neg_res ? -quo : quo;
	assign rem_fix  = neg_rem ? -rem[XLEN-1:0] : rem[XLEN-1:0];

	always_comb begin
		if (is_div) begin
			raw = sel_hi ? rem_fix : quo_fix;
		end else begin
			raw = sel_hi ? prod_fix[2*XLEN-1:XLEN] : prod_fix[XLEN-1:0];
		end
		final_res = is_word ? {{(XLEN-32){raw[31]}}, raw[31:0]} : raw;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			done   <= 1'b0;
			cnt    <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				active <= 1'b1;
				cnt    <= CW'(STEPS);
			end else if (active) begin
				if (cnt == '0) begin
					active <= 1'b0;
					done   <= 1'b1;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			is_div  <= dec.func3[2];
			is_word <= word_in;
			sel_hi  <= dec.func3[2] ? dec.func3[1] : (dec.func3 != 3'd0);
			// A zero divisor keeps the all-ones quotient unsigned.
			neg_res <= (a_neg ^ b_neg) && !(dec.func3[2] && src_b == '0);
			neg_rem <= a_neg;
			prod    <= '0;
			mcand   <= {{XLEN{1'b0}}, mag_a};
			mplier  <= mag_b;
			rem     <= '0;
			quo     <= mag_a;
			dsor    <= mag_b;
		end else if (active && cnt != '0) begin
			prod   <= prod_nx;
			mcand  <= mcand << MD_BITS_PER_CYCLE;
			mplier <= mplier >> MD_BITS_PER_CYCLE;
			rem    <= rem_nx;
			quo    <= quo_nx;
		end
		if (active && cnt == '0) begin
			result <= final_res;
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		start |-> !active)
		else $error("mul/div start while an operation is active");

	a_done_after_start: assert property (@(posedge clk) disable iff (reset)
		done |-> $past(start, STEPS + 2))
		else $error("mul/div done without a matching start");

endmodule

//--- rtl/rv_issue_ctrl.sv
module rv_issue_ctrl (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           instr_valid,
	input  logic [rv_isa_pkg::ILEN-1:0]    instr,
	input  logic [rv_exec_pkg::XLEN-1:0]   pc,
	rv_dec_if.consumer                     dec,
	input  logic [rv_exec_pkg::XLEN-1:0]   alu_result,
	input  logic                           branch_taken,
	input  logic [rv_exec_pkg::XLEN-1:0]   target,
	input  logic                           md_done,
	input  logic [rv_exec_pkg::XLEN-1:0]   md_result,
	output logic                           md_start,
	output logic [rv_isa_pkg::ILEN-1:0]    instr_q,
	output logic [rv_exec_pkg::XLEN-1:0]   pc_q,
	output logic                           busy,
	output logic                           wb_valid,
	output logic [rv_exec_pkg::REG_AW-1:0] wb_rd,
	output logic [rv_exec_pkg::XLEN-1:0]   wb_data,
	output logic                           redirect_valid,
	output logic [rv_exec_pkg::XLEN-1:0]   redirect_pc,
	output logic                           illegal
);
	import rv_isa_pkg::*;

	typedef enum logic [1:0] {IDLE, EXEC, MD_WAIT, RETIRE} state_e;

	state_e state;
	logic   accept;
	logic   legal_op;
	logic   ret_wb;
	logic   ret_redir;
	logic   ret_ill;

	assign busy     = state != IDLE;
	assign accept   = instr_valid && !busy;
	assign md_start = state == EXEC && dec.mul_en;
	assign legal_op = dec.opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
		OPC_OP_IMM, OPC_OP, OPC_OP_IMM_32, OPC_OP_32};

	// ####################
	// Sequencing
	// ####################

	always_ff @(posedge clk) begin
		if (reset) begin
			state          <= IDLE;
			ret_wb         <= 1'b0;
			ret_redir      <= 1'b0;
			ret_ill        <= 1'b0;
			wb_valid       <= 1'b0;
			redirect_valid <= 1'b0;
			illegal        <= 1'b0;
		end else begin
			wb_valid       <= 1'b0;
			redirect_valid <= 1'b0;
			illegal        <= 1'b0;
			case (state)
				IDLE: if (accept) state <= EXEC;
				EXEC: begin
					ret_ill   <= !legal_op;
					ret_wb    <= legal_op && dec.opcode != OPC_BRANCH; // Branches have no rd.
					ret_redir <= legal_op && branch_taken;
					state     <= dec.mul_en ? MD_WAIT : RETIRE;
				end
				MD_WAIT: if (md_done) state <= RETIRE;
				default: begin
					wb_valid       <= ret_wb;
					redirect_valid <= ret_redir;
					illegal        <= ret_ill;
					state          <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			instr_q <= instr;
			pc_q    <= pc;
		end
		if (state == EXEC) begin
			wb_rd       <= dec.rd;
			wb_data     <= alu_result;
			redirect_pc <= target;
		end
		if (state == MD_WAIT && md_done) begin
			wb_data <= md_result;
		end
	end

	a_no_issue_when_busy: assert property (@(posedge clk) disable iff (reset)
		instr_valid |-> !busy)
		else $error("instr_valid asserted while core is busy");

endmodule

//--- rtl/rv_int_core.sv
module rv_int_core #(
	parameter int MD_BITS_PER_CYCLE = 2
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           instr_valid,
	input  logic [rv_isa_pkg::ILEN-1:0]    instr,
	input  logic [rv_exec_pkg::XLEN-1:0]   pc,
	output logic                           busy,
	output logic                           wb_valid,
	output logic [rv_exec_pkg::REG_AW-1:0] wb_rd,
	output logic [rv_exec_pkg::XLEN-1:0]   wb_data,
	output logic                           redirect_valid,
	output logic [rv_exec_pkg::XLEN-1:0]   redirect_pc,
	output logic                           illegal
);
	import rv_isa_pkg::*;
	import rv_exec_pkg::*;

	logic [ILEN-1:0] instr_q;
	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] alu_result;
	logic            branch_taken;
	logic [XLEN-1:0] target;
	logic            md_start;
	logic            md_done;
	logic [XLEN-1:0] md_result;

	rv_dec_if dec_bus ();

	rv_decode u_decode (
		.instr (instr_q),
		.dec   (dec_bus.dec)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.reset    (reset),
		.dec      (dec_bus.consumer),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr_en    (wb_valid), // Writeback lands one edge after the pulse forms.
		.wr_addr  (wb_rd),
		.wr_data  (wb_data)
	);

	rv_alu u_alu (
		.dec          (dec_bus.consumer),
		.pc           (pc_q),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.result       (alu_result),
		.branch_taken (branch_taken),
		.target       (target)
	);

	rv_muldiv #(
		.MD_BITS_PER_CYCLE (MD_BITS_PER_CYCLE)
	) u_muldiv (
		.clk      (clk),
		.reset    (reset),
		.start    (md_start),
		.dec      (dec_bus.consumer),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.done     (md_done),
		.result   (md_result)
	);

	rv_issue_ctrl u_issue_ctrl (
		.clk            (clk),
		.reset          (reset),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.pc             (pc),
		.dec            (dec_bus.consumer),
		.alu_result     (alu_result),
		.branch_taken   (branch_taken),
		.target         (target),
		.md_done        (md_done),
		.md_result      (md_result),
		.md_start       (md_start),
		.instr_q        (instr_q),
		.pc_q           (pc_q),
		.busy           (busy),
		.wb_valid       (wb_valid),
		.wb_rd          (wb_rd),
		.wb_data        (wb_data),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.illegal        (illegal)
	);

endmodule

//--- tb/rv_int_core_tb.sv
module rv_int_core_tb;
	import rv_isa_pkg::*;
	import rv_exec_pkg::*;

	localparam int TIMEOUT = 200;

	logic              clk = 1'b0;
	logic              reset;
	logic              instr_valid;
	logic [ILEN-1:0]   instr;
	logic [XLEN-1:0]   pc;
	logic              busy;
	logic              wb_valid;
	logic [REG_AW-1:0] wb_rd;
	logic [XLEN-1:0]   wb_data;
	logic              redirect_valid;
	logic [XLEN-1:0]   redirect_pc;
	logic              illegal;

	logic [XLEN-1:0]   shadow [NUM_REGS]; // Expected architectural state.
	logic [31:0]       lcg_state = 32'd42249;
	int                checks = 0;
	int                errors = 0;
	logic              got_wb;
	logic              got_redir;
	logic              got_ill;
	logic [REG_AW-1:0] got_rd;
	logic [XLEN-1:0]   got_data;
	logic [XLEN-1:0]   got_rpc;

	rv_int_core #(.MD_BITS_PER_CYCLE(2)) uut (.*);

	always #2 clk = ~clk;

	// ####################
	// Encoders and models
	// ####################

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		hi = next_rand();
		return {hi, next_rand()};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic [63:0] ref_alu(input logic [6:0] opc, input logic [2:0] f3,
		input logic alt, input logic [63:0] a, input logic [63:0] b);
		logic [31:0]        w;
		logic [63:0]        r;
		logic signed [63:0] sa;
		logic signed [31:0] sw;
		sa = a;
		sw = a[31:0];
		if (opc == OPC_OP_32 || opc == OPC_OP_IMM_32) begin
			if (f3 == 3'd1)
				w = a[31:0] << b[4:0];
			else if (f3 == 3'd5 && alt)
				w = sw >>> b[4:0];
			else if (f3 == 3'd5)
				w = a[31:0] >> b[4:0];
			else if (alt && opc == OPC_OP_32)
				w = a[31:0] - b[31:0];
			else
				w = a[31:0] + b[31:0];
			return {{32{w[31]}}, w}; // Word results are sign-extended.
		end
		case (f3)
			3'd0: r = (alt && opc == OPC_OP) ? a - b : a + b;
			3'd1: r = a << b[5:0];
			3'd2: r = {63'b0, $signed(a) < $signed(b)};
			3'd3: r = {63'b0, a < b};
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt)
					r = sa >>> b[5:0];
				else
					r = a >> b[5:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic [63:0] ref_md(input logic [2:0] f3, input logic word,
		input logic [63:0] a, input logic [63:0] b);
		logic [127:0]       ea;
		logic [127:0]       eb;
		logic [127:0]       p;
		logic [63:0]        x;
		logic [63:0]        y;
		logic [63:0]        r;
		logic signed [63:0] sx;
		logic signed [63:0] sy;
		logic               ovf;
		x = a;
		y = b;
		if (word && (f3 == 3'd5 || f3 == 3'd7)) begin
			x = {32'b0, a[31:0]};
			y = {32'b0, b[31:0]};
		end else if (word) begin
			x = {{32{a[31]}}, a[31:0]};
			y = {{32{b[31]}}, b[31:0]};
		end
		sx  = x;
		sy  = y;
		ovf = x == {1'b1, 63'b0} && y == '1;
		ea  = (f3 == 3'd1 || f3 == 3'd2) ? {{64{x[63]}}, x} : {64'b0, x};
		eb  = (f3 == 3'd1) ? {{64{y[63]}}, y} : {64'b0, y};
		p   = ea * eb;
		case (f3)
			3'd0: r = p[63:0];
			3'd1, 3'd2, 3'd3: r = p[127:64];
			3'd4: r = (y == 0) ? '1 : ovf ? x : $unsigned(sx / sy);
			3'd5: r = (y == 0) ? '1 : x / y;
			3'd6: r = (y == 0) ? x : ovf ? '0 : $unsigned(sx % sy);
			default: r = (y == 0) ? x : x % y;
		endcase
		if (word)
			r = {{32{r[31]}}, r[31:0]};
		return r;
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [63:0] a,
		input logic [63:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// ####################
	// Drive and check
	// ####################

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (act === exp)
		else begin
			errors++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		checks++;
		assert (cond)
		else begin
			errors++;
			$display("%0t: %s", $time, msg);
		end
	endtask

	task automatic issue(input logic [31:0] ins, input logic [63:0] ipc);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= ins;
		pc          <= ipc;
		@(posedge clk); // Accept edge.
		instr_valid <= 1'b0;
	endtask

	task automatic wait_result(output int cycles);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (busy && n < TIMEOUT);
		if (busy) begin
			$display("timeout: core still busy after %0d cycles", n);
			$display("Simulation FAILED");
			$finish;
		end else begin
			got_wb    = wb_valid;
			got_rd    = wb_rd;
			got_data  = wb_data;
			got_redir = redirect_valid;
			got_rpc   = redirect_pc;
			got_ill   = illegal;
			cycles    = n;
		end
	endtask

	task automatic run(input logic [31:0] ins, input logic [63:0] ipc, output int cycles);
		issue(ins, ipc);
		wait_result(cycles);
	endtask

	task automatic expect_wb(input logic [4:0] rd, input logic [63:0] exp);
		check_val("wb_valid", 1, got_wb);
		check_val("wb_rd", rd, got_rd);
		check_val("wb_data", exp, got_data);
		check_val("illegal", 0, got_ill);
		if (rd != 0)
			shadow[rd] = exp;
	endtask

	task automatic op_imm(input logic [6:0] opc, input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		logic [63:0] exp;
		int          cyc;
		exp = ref_alu(opc, f3, imm[10] && f3 == 3'd5, shadow[rs1], {{52{imm[11]}}, imm});
		run(enc_i(imm, rs1, f3, rd, opc), 64'h1000, cyc);
		check_val("alu latency", 3, cyc); // Pulse lands 2 edges after accept.
		expect_wb(rd, exp);
	endtask

	task automatic op_reg(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		logic [63:0] exp;
		int          cyc;
		if (f7[0])
			exp = ref_md(f3, opc == OPC_OP_32, shadow[rs1], shadow[rs2]);
		else
			exp = ref_alu(opc, f3, f7[5], shadow[rs1], shadow[rs2]);
		run(enc_r(f7, rs2, rs1, f3, rd, opc), 64'h2000, cyc);
		if (f7[0])
			check_true(cyc > 3, "mul/div finished without iterating");
		else
			check_val("alu latency", 3, cyc);
		expect_wb(rd, exp);
	endtask

	// Builds a 64-bit value from a 9-bit seed and five shifted 11-bit chunks.
	task automatic load_reg(input logic [4:0] rd, input logic [63:0] v);
		op_imm(OPC_OP_IMM, 3'd0, rd, 5'd0, {3'b0, v[63:55]});
		for (int k = 4; k >= 0; k--) begin
			op_imm(OPC_OP_IMM, 3'd1, rd, rd, 12'd11);
			op_imm(OPC_OP_IMM, 3'd6, rd, rd, {1'b0, v[k*11 +: 11]});
		end
	endtask

	task automatic report(input string name, input int e0);
		$display("test %s finished with %0d errors", name, errors - e0);
	endtask

	// ####################
	// Tests
	// ####################

	task automatic test_immediates();
		int          e0;
		int          cyc;
		logic [19:0] u;
		logic [63:0] upc;
		e0 = errors;
		for (int i = 0; i < 4; i++)
			op_imm(OPC_OP_IMM, 3'd0, 5'(5 + i), 5'd0, next_rand() & 12'hfff);
		op_imm(OPC_OP_IMM_32, 3'd0, 5'd9, 5'd5, next_rand() & 12'hfff);
		for (int i = 0; i < 3; i++) begin
			u   = next_rand() & 20'hfffff;
			upc = rand64() & ~64'h3;
			run({u, 5'd10, OPC_LUI}, upc, cyc);
			check_val("alu latency", 3, cyc);
			expect_wb(5'd10, {{32{u[19]}}, u, 12'b0});
			run({u, 5'd11, OPC_AUIPC}, upc, cyc);
			expect_wb(5'd11, upc + {{32{u[19]}}, u, 12'b0});
		end
		op_imm(OPC_OP_IMM, 3'd0, 5'd0, 5'd5, 12'h7ff); // Dropped by the register file.
		op_imm(OPC_OP_IMM, 3'd0, 5'd12, 5'd0, 12'd0);
		check_val("x0 readback", 0, got_data);
		report("immediates", e0);
	endtask

	task automatic test_reg_ops();
		int e0;
		e0 = errors;
		for (int r = 1; r <= 4; r++)
			load_reg(5'(r), rand64());
		for (int f = 0; f < 8; f++) begin
			op_reg(OPC_OP, 3'(f), 7'h00, 5'd13, 5'd1, 5'd2);
			op_reg(OPC_OP, 3'(f), 7'h00, 5'd14, 5'd3, 5'd4);
		end
		op_reg(OPC_OP, 3'd0, 7'h20, 5'd15, 5'd1, 5'd2);
		op_reg(OPC_OP, 3'd5, 7'h20, 5'd15, 5'd3, 5'd4);
		op_reg(OPC_OP, 3'd2, 7'h00, 5'd16, 5'd2, 5'd1);
		op_reg(OPC_OP, 3'd3, 7'h00, 5'd16, 5'd2, 5'd1);
		op_reg(OPC_OP_32, 3'd0, 7'h00, 5'd17, 5'd1, 5'd2);
		op_reg(OPC_OP_32, 3'd0, 7'h20, 5'd17, 5'd3, 5'd4);
		op_reg(OPC_OP_32, 3'd1, 7'h00, 5'd17, 5'd1, 5'd2);
		op_reg(OPC_OP_32, 3'd5, 7'h00, 5'd17, 5'd3, 5'd4);
		op_reg(OPC_OP_32, 3'd5, 7'h20, 5'd17, 5'd1, 5'd2);
		report("register ops", e0);
	endtask

	task automatic test_branches();
		int          e0;
		int          cyc;
		logic [63:0] pa [3];
		logic [63:0] pb [3];
		logic [12:0] bimm;
		logic [11:0] jimm;
		logic [20:0] limm;
		logic [63:0] bpc;
		logic        taken;
		e0 = errors;
		pa = '{64'd5, -64'd3, 64'd7};
		pb = '{64'd5, 64'd7, -64'd3};
		for (int p = 0; p < 3; p++) begin
			load_reg(5'd1, pa[p]);
			load_reg(5'd2, pb[p]);
			for (int f = 0; f < 8; f++) begin
				if (f == 2 || f == 3)
					continue;
				bimm  = next_rand() & 13'h1ffe;
				bpc   = rand64() & ~64'h3;
				taken = branch_ref(3'(f), shadow[1], shadow[2]);
				run(enc_b(bimm, 5'd2, 5'd1, 3'(f)), bpc, cyc);
				check_val("redirect_valid", taken, got_redir);
				check_val("wb_valid", 0, got_wb);
				if (taken)
					check_val("redirect_pc", bpc + {{51{bimm[12]}}, bimm}, got_rpc);
			end
		end
		limm = next_rand() & 21'h1ffffe;
		bpc  = rand64() & ~64'h3;
		run(enc_j(limm, 5'd5), bpc, cyc);
		expect_wb(5'd5, bpc + 64'd4);
		check_val("redirect_valid", 1, got_redir);
		check_val("redirect_pc", bpc + {{43{limm[20]}}, limm}, got_rpc);
		load_reg(5'd1, rand64() | 64'd1);
		jimm = next_rand() & 12'hffe;
		run(enc_i(jimm, 5'd1, 3'd0, 5'd6, OPC_JALR), bpc, cyc);
		check_val("redirect_pc", (shadow[1] + {{52{jimm[11]}}, jimm}) & ~64'd1, got_rpc);
		check_val("redirect_valid", 1, got_redir);
		expect_wb(5'd6, bpc + 64'd4);
		report("branches", e0);
	endtask

	task automatic test_muldiv();
		int e0;
		e0 = errors;
		load_reg(5'd1, rand64());
		load_reg(5'd2, rand64() >> 20); // Smaller divisor gives a nontrivial quotient.
		load_reg(5'd3, 64'd0);
		load_reg(5'd4, {1'b1, 63'b0});
		load_reg(5'd5, '1);
		load_reg(5'd6, 64'hffffffff_80000000);
		for (int f = 0; f < 8; f++) begin
			op_reg(OPC_OP, 3'(f), 7'h01, 5'd20, 5'd1, 5'd2);
			op_reg(OPC_OP, 3'(f), 7'h01, 5'd21, 5'd5, 5'd1);
			if (f >= 4) begin
				op_reg(OPC_OP, 3'(f), 7'h01, 5'd22, 5'd1, 5'd3);
				op_reg(OPC_OP, 3'(f), 7'h01, 5'd22, 5'd4, 5'd5);
				op_reg(OPC_OP_32, 3'(f), 7'h01, 5'd23, 5'd1, 5'd2);
				op_reg(OPC_OP_32, 3'(f), 7'h01, 5'd23, 5'd1, 5'd3);
				op_reg(OPC_OP_32, 3'(f), 7'h01, 5'd23, 5'd6, 5'd5);
			end
		end
		op_reg(OPC_OP_32, 3'd0, 7'h01, 5'd24, 5'd1, 5'd2);
		report("mul/div", e0);
	endtask

	task automatic test_illegal();
		int          e0;
		int          cyc;
		logic [31:0] bad [4];
		e0  = errors;
		load_reg(5'd7, rand64());
		bad = '{enc_i(12'h010, 5'd1, 3'd3, 5'd7, OPC_LOAD),
			enc_i(12'h000, 5'd1, 3'd3, 5'd7, OPC_STORE),
			enc_i(12'h300, 5'd1, 3'd5, 5'd7, OPC_SYSTEM),
			enc_i(12'h0ff, 5'd0, 3'd0, 5'd7, OPC_FENCE)};
		foreach (bad[i]) begin
			run(bad[i], 64'h3000, cyc);
			check_val("illegal", 1, got_ill);
			check_val("wb_valid", 0, got_wb);
			op_imm(OPC_OP_IMM, 3'd0, 5'd8, 5'd7, 12'd0); // x7 must be unchanged.
		end
		report("illegal", e0);
	endtask

	task automatic test_back_to_back();
		int e0;
		int cyc;
		e0 = errors;
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= enc_i(12'd123, 5'd0, 3'd0, 5'd9, OPC_OP_IMM);
		@(posedge clk);
		instr_valid <= 1'b0;
		@(posedge clk);
		@(posedge clk); // Busy falls on this edge.
		instr_valid <= 1'b1;
		instr       <= enc_i(12'd1, 5'd9, 3'd0, 5'd10, OPC_OP_IMM);
		@(negedge clk);
		check_val("busy", 0, busy);
		check_val("wb_data", 64'd123, wb_data);
		shadow[9] = 64'd123;
		@(posedge clk);
		instr_valid <= 1'b0;
		@(negedge clk);
		check_true(busy, "second instruction was not accepted back to back");
		wait_result(cyc);
		expect_wb(5'd10, 64'd124);
		report("back-to-back", e0);
	endtask

	initial begin
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = '0;
		foreach (shadow[i])
			shadow[i] = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_val("busy", 0, busy);
		check_val("wb_valid", 0, wb_valid);
		check_val("illegal", 0, illegal);
		test_immediates();
		test_reg_ops();
		test_branches();
		test_muldiv();
		test_illegal();
		test_back_to_back();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- rv_int_core.f
rtl/rv_isa_pkg.sv
rtl/rv_exec_pkg.sv
rtl/rv_dec_if.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_muldiv.sv
rtl/rv_issue_ctrl.sv
rtl/rv_int_core.sv
tb/rv_int_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_int_core_tb
FILELIST  ?= rv_int_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
